/* uart_pkg.sv */
// shared types and constants for the serial debug UART, referenced by scoped names
`default_nettype none

package uart_pkg;

    // one bit period lasts baud_div + 1 clock cycles
    typedef logic [15:0] baud_div_t;

    // smallest divisor that still leaves a usable half-bit start check
    localparam baud_div_t min_baud_div = 16'd3;

    // one received frame as it sits in the receive FIFO
    typedef struct packed {
        logic [7:0] data;       // received byte, bit 0 first on the wire
        logic       frame_err;  // stop bit was sampled low
    } rx_entry_t;

    // line terminators sent by the hex logger
    localparam logic [7:0] ascii_cr = 8'h0d;
    localparam logic [7:0] ascii_lf = 8'h0a;

endpackage

`default_nettype wire

/* uart_rx.sv */
// 8N1 receive engine, fed from a synchronized pin, pulses done with each frame
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire uart_pkg::baud_div_t baud_div,
    input  wire logic                rx_pin,
    output logic                     done,
    output uart_pkg::rx_entry_t      entry
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t           state;
    uart_pkg::baud_div_t bit_timer;
    logic [2:0]          bit_index;
    logic                pin_q;      // previous pin level, for edge detect
    logic                timer_zero;
    logic                start_edge;

    assign timer_zero = (bit_timer == '0);
    assign start_edge = pin_q && !rx_pin;   // only a falling edge opens a frame

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            done      <= 1'b0;
            pin_q     <= 1'b1;
        end else begin
            pin_q <= rx_pin;
            done  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_edge) begin
                        state     <= ST_START;
                        bit_timer <= baud_div >> 1;  // go to middle of start bit
                    end
                end
                ST_START: begin
                    if (timer_zero) begin
                        if (rx_pin) begin
                            state <= ST_IDLE;        // glitch, not a start bit
                        end else begin
                            state     <= ST_DATA;
                            bit_timer <= baud_div;
                            bit_index <= '0;
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                ST_DATA: begin
                    if (timer_zero) begin
                        bit_timer <= baud_div;
                        if (bit_index == 3'd7) begin
                            state <= ST_STOP;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                ST_STOP: begin
                    if (timer_zero) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // sampled bits land straight in the output entry
    always_ff @(posedge clk) begin
        if (state == ST_DATA && timer_zero) entry.data[bit_index] <= rx_pin;
        if (state == ST_STOP && timer_zero) entry.frame_err <= !rx_pin;
    end

    a_done_single: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done);

    a_div_min: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_IDLE && start_edge) |-> baud_div >= uart_pkg::min_baud_div);

endmodule

`default_nettype wire

/* uart_tx.sv */
// 8N1 transmit engine, one frame per start strobe, registered pin output
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire uart_pkg::baud_div_t baud_div,
    input  wire logic                start,
    input  wire logic [7:0]          data,
    output logic                     tx_pin,
    output logic                     busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

    tx_state_t           state;
    uart_pkg::baud_div_t bit_timer;
    logic [2:0]          bit_index;
    logic [7:0]          data_latch;
    logic                timer_zero;

    assign timer_zero = (bit_timer == '0);
    assign busy       = (state != ST_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            tx_pin    <= 1'b1;  // line idles high
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        tx_pin    <= 1'b0;  // start bit
                        bit_timer <= baud_div;
                        bit_index <= '0;
                        state     <= ST_START;
                    end
                end
                ST_START: begin
                    if (timer_zero) begin
                        tx_pin    <= data_latch[0];
                        bit_timer <= baud_div;
                        state     <= ST_DATA;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                ST_DATA: begin
                    if (timer_zero) begin
                        bit_timer <= baud_div;
                        if (bit_index == 3'd7) begin
                            tx_pin <= 1'b1;  // stop bit
                            state  <= ST_STOP;
                        end else begin
                            tx_pin    <= data_latch[3'(bit_index + 3'd1)];
                            bit_index <= bit_index + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                ST_STOP: begin
                    if (timer_zero) state <= ST_IDLE;  // frame done
                    else bit_timer <= bit_timer - 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == ST_IDLE) data_latch <= data;
    end

    // a start during a frame would be lost, and too small a divisor breaks the receiver
    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy && baud_div >= uart_pkg::min_baud_div);

endmodule

`default_nettype wire

/* sync_fifo.sv */
// show-ahead synchronous FIFO with a type parameter for the payload
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH = 16,           // power of two
    parameter type T     = logic [7:0]
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic push,
    input  wire T     push_data,
    input  wire logic pop,
    output T          pop_data,
    output logic      full,
    output logic      empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;          // count reaches DEPTH

    T                mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];       // head is visible before the pop

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    // the owner gates push and pop with full and empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

`default_nettype wire

/* uart_core.sv */
// full duplex UART with transmit and receive FIFOs around the 8N1 engines
`timescale 1ns/100ps
`default_nettype none

module uart_core #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire uart_pkg::baud_div_t baud_div,
    input  wire logic                tx_write,
    input  wire logic [7:0]          tx_data,
    output logic                     tx_full,
    output logic                     tx_pin,
    input  wire logic                rx_pin,
    input  wire logic                rx_read,
    output logic                     rx_ready,
    output uart_pkg::rx_entry_t      rx_entry
);

    // transmit side
    logic       tx_empty;
    logic [7:0] tx_head;
    logic       tx_busy;
    logic       tx_start;

    // receive side
    logic [1:0]          rx_sync;    // two-flop synchronizer
    logic                rx_done;
    uart_pkg::rx_entry_t rx_new;
    logic                rx_full;
    logic                rx_empty;

    assign tx_start = !tx_empty && !tx_busy;  // engine takes the head on this edge
    assign rx_ready = !rx_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) rx_sync <= 2'b11;
        else rx_sync <= {rx_sync[0], rx_pin};
    end

    sync_fifo #(.DEPTH(FIFO_DEPTH), .T(logic [7:0])) u_tx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (tx_write && !tx_full),  // writes while full are lost
        .push_data (tx_data),
        .pop       (tx_start),
        .pop_data  (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    uart_tx u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .baud_div (baud_div),
        .start    (tx_start),
        .data     (tx_head),
        .tx_pin   (tx_pin),
        .busy     (tx_busy)
    );

    uart_rx u_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .baud_div (baud_div),
        .rx_pin   (rx_sync[1]),
        .done     (rx_done),
        .entry    (rx_new)
    );

    sync_fifo #(.DEPTH(FIFO_DEPTH), .T(uart_pkg::rx_entry_t)) u_rx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (rx_done && !rx_full),   // overrun drops the new frame
        .push_data (rx_new),
        .pop       (rx_read && !rx_empty),
        .pop_data  (rx_entry),
        .full      (rx_full),
        .empty     (rx_empty)
    );

endmodule

`default_nettype wire

/* hex_logger.sv */
// prints a 16-bit value as four hex digits plus CR LF on its own serial pin
`timescale 1ns/100ps
`default_nettype none

module hex_logger (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire uart_pkg::baud_div_t baud_div,
    input  wire logic                trigger,
    input  wire logic [15:0]         hex_val,
    output logic                     log_pin,
    output logic                     busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,    // start each character once the transmitter is free
        ST_DRAIN    // last frame still on the wire
    } log_state_t;

    log_state_t  state;
    logic [2:0]  char_idx;   // 0..3 digits, 4 cr, 5 lf
    logic [15:0] val_latch;
    logic [3:0]  nibble;
    logic [7:0]  char_data;
    logic        tx_busy;
    logic        tx_start;

    assign busy     = (state != ST_IDLE);
    assign tx_start = (state == ST_SEND) && !tx_busy;

    always_comb begin
        nibble = val_latch[4'(4'd12 - 4'(char_idx) * 4'd4) +: 4];  // msb nibble first
        case (char_idx)
            3'd4:    char_data = uart_pkg::ascii_cr;
            3'd5:    char_data = uart_pkg::ascii_lf;
            default: char_data = (nibble < 4'd10) ? 8'h30 + 8'(nibble)  // '0'..'9'
                                                  : 8'h37 + 8'(nibble); // 'A'..'F'
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            char_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (trigger) begin
                        char_idx <= '0;
                        state    <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (tx_start) begin
                        char_idx <= char_idx + 1'b1;
                        if (char_idx == 3'd5) state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: if (!tx_busy) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (trigger && state == ST_IDLE) val_latch <= hex_val;
    end

    uart_tx u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .baud_div (baud_div),
        .start    (tx_start),
        .data     (char_data),
        .tx_pin   (log_pin),
        .busy     (tx_busy)
    );

endmodule

`default_nettype wire

/* serial_debug_top.sv */
// top level of the serial debug block, UART core plus hex logger on one divisor
`timescale 1ns/100ps
`default_nettype none

module serial_debug_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire uart_pkg::baud_div_t baud_div,
    input  wire logic                tx_write,
    input  wire logic [7:0]          tx_data,
    output logic                     tx_full,
    output logic                     tx_pin,
    input  wire logic                rx_pin,
    input  wire logic                rx_read,
    output logic                     rx_ready,
    output uart_pkg::rx_entry_t      rx_entry,
    input  wire logic                log_trigger,
    input  wire logic [15:0]         log_value,
    output logic                     log_pin,
    output logic                     log_busy
);

    uart_core #(.FIFO_DEPTH(FIFO_DEPTH)) u_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .baud_div (baud_div),
        .tx_write (tx_write),
        .tx_data  (tx_data),
        .tx_full  (tx_full),
        .tx_pin   (tx_pin),
        .rx_pin   (rx_pin),
        .rx_read  (rx_read),
        .rx_ready (rx_ready),
        .rx_entry (rx_entry)
    );

    hex_logger u_logger (
        .clk      (clk),
        .arst_n   (arst_n),
        .baud_div (baud_div),
        .trigger  (log_trigger),
        .hex_val  (log_value),
        .log_pin  (log_pin),
        .busy     (log_busy)
    );

endmodule

`default_nettype wire

/* tb_serial_debug.sv */
// directed testbench for serial_debug_top, run with the file list and tb_serial_debug as top
`timescale 1ns/100ps
`default_nettype none

module tb_serial_debug;

    localparam int div_val      = 7;
    localparam int bit_cycles   = div_val + 1;
    localparam int frame_cycles = 10 * bit_cycles;
    // tx order 10, back-pressure 8, receive 7, overflow 8, logger 9
    localparam int total_frames = 42;

    logic                clk;
    logic                arst_n;
    uart_pkg::baud_div_t baud_div;
    logic                tx_write;
    logic [7:0]          tx_data;
    logic                tx_full;
    logic                tx_pin;
    logic                rx_pin;
    logic                rx_read;
    logic                rx_ready;
    uart_pkg::rx_entry_t rx_entry;
    logic                log_trigger;
    logic [15:0]         log_value;
    logic                log_pin;
    logic                log_busy;

    int          errors    = 0;
    int          checks    = 0;
    int          tests_run = 0;
    logic [15:0] lfsr      = 16'd32851;

    serial_debug_top #(.FIFO_DEPTH(4)) uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .baud_div    (baud_div),
        .tx_write    (tx_write),
        .tx_data     (tx_data),
        .tx_full     (tx_full),
        .tx_pin      (tx_pin),
        .rx_pin      (rx_pin),
        .rx_read     (rx_read),
        .rx_ready    (rx_ready),
        .rx_entry    (rx_entry),
        .log_trigger (log_trigger),
        .log_value   (log_value),
        .log_pin     (log_pin),
        .log_busy    (log_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^15 + x^13 + x^4 + 1, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) return 8'h30 + 8'(n);  // '0'
        return 8'h41 + 8'(n) - 8'd10;          // 'A'
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp_val, input logic [7:0] act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic check_entry(input string name, input uart_pkg::rx_entry_t exp_val,
                               input uart_pkg::rx_entry_t act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("ERROR %s: expected data %h err %b, actual data %h err %b",
                     name, exp_val.data, exp_val.frame_err, act.data, act.frame_err);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp_val, act);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - errors_before);
    endtask

    // which 0 waits for rx_ready high, which 1 for log_busy low
    task automatic wait_for(input string name, input int which, input int limit);
        int n;
        n = 0;
        while ((which == 0 ? !rx_ready : log_busy) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (which == 0 ? !rx_ready : log_busy) begin
            errors++;
            $display("%s: %s did not change within %0d cycles", name,
                     which == 0 ? "rx_ready" : "log_busy", limit);
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input bit stop_low);
        int i;
        rx_pin = 1'b0;
        repeat (bit_cycles) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx_pin = data[i];  // lsb first
            repeat (bit_cycles) @(negedge clk);
        end
        rx_pin = !stop_low;
        repeat (bit_cycles) @(negedge clk);
        rx_pin = 1'b1;         // one idle bit between frames
        repeat (bit_cycles) @(negedge clk);
    endtask

    // samples each bit near its middle after the start edge
    task automatic decode_frame(input bit use_log, output logic [7:0] data, output logic stop);
        int i;
        if (use_log) @(negedge log_pin);
        else @(negedge tx_pin);
        repeat (bit_cycles / 2) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(negedge clk);
            data[i] = use_log ? log_pin : tx_pin;
        end
        repeat (bit_cycles) @(negedge clk);
        stop = use_log ? log_pin : tx_pin;
    endtask

    task automatic expect_quiet(input string name, input bit use_log, input int cycles);
        logic line_min;
        line_min = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            line_min = line_min & (use_log ? log_pin : tx_pin);
        end
        check_bit(name, 1'b1, line_min);
    endtask

    task automatic pop_entry();
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_bit("reset tx_pin", 1'b1, tx_pin);
        check_bit("reset log_pin", 1'b1, log_pin);
        check_bit("reset tx_full", 1'b0, tx_full);
        check_bit("reset rx_ready", 1'b0, rx_ready);
        check_bit("reset log_busy", 1'b0, log_busy);
        report_test("reset_state", e0);
    endtask

    task automatic test_tx_order();
        logic [7:0]  sent [10];
        logic [7:0]  got;
        logic        stop;
        logic [15:0] r;
        int          i;
        int          k;
        int          e0;
        e0 = errors;
        for (i = 0; i < 10; i++) begin
            r       = rand_bits(8);
            sent[i] = r[7:0];
        end
        fork
            begin
                for (i = 0; i < 10; i++) begin
                    while (tx_full) @(negedge clk);
                    tx_write = 1'b1;
                    tx_data  = sent[i];
                    @(negedge clk);
                end
                tx_write = 1'b0;
            end
            for (k = 0; k < 10; k++) begin
                decode_frame(1'b0, got, stop);
                check_byte("tx_order data", sent[k], got);
                check_bit("tx_order stop", 1'b1, stop);
            end
        join
        report_test("tx_order", e0);
    endtask

    task automatic test_tx_backpressure();
        logic [7:0]  accepted [$];
        logic [7:0]  got;
        logic        stop;
        logic [15:0] r;
        int          k;
        int          e0;
        e0 = errors;
        fork
            begin
                repeat (24) begin
                    r        = rand_bits(8);
                    tx_write = 1'b1;
                    tx_data  = r[7:0];
                    if (!tx_full) accepted.push_back(r[7:0]);  // taken on the next edge
                    @(negedge clk);
                end
                tx_write = 1'b0;
            end
            begin
                k = 0;
                do begin
                    decode_frame(1'b0, got, stop);
                    check_byte("tx_backpressure data", accepted[k], got);
                    check_bit("tx_backpressure stop", 1'b1, stop);
                    k++;
                end while (k < accepted.size());
            end
        join
        expect_quiet("tx_backpressure extra frame", 1'b0, 2 * frame_cycles);
        report_test("tx_backpressure", e0);
    endtask

    task automatic test_rx();
        uart_pkg::rx_entry_t exp_entry;
        logic [15:0]         r;
        int                  i;
        int                  e0;
        e0 = errors;
        for (i = 0; i < 4; i++) begin
            r = rand_bits(8);
            send_frame(r[7:0], i == 3);  // last frame has a low stop bit
            wait_for("rx", 0, frame_cycles);
            exp_entry.data      = r[7:0];
            exp_entry.frame_err = (i == 3);
            check_entry("rx entry", exp_entry, rx_entry);
            pop_entry();
        end
        rx_pin = 1'b0;                   // glitch of half a bit
        repeat (bit_cycles / 2) @(negedge clk);
        rx_pin = 1'b1;
        repeat (frame_cycles) @(negedge clk);
        check_bit("rx glitch", 1'b0, rx_ready);
        report_test("rx", e0);
    endtask

    task automatic test_rx_overflow();
        uart_pkg::rx_entry_t exp_entry;
        logic [7:0]          sent [6];
        logic [15:0]         r;
        int                  i;
        int                  e0;
        e0 = errors;
        for (i = 0; i < 6; i++) begin
            r       = rand_bits(8);
            sent[i] = r[7:0];
            send_frame(sent[i], 1'b0);
        end
        for (i = 0; i < 4; i++) begin
            wait_for("rx_overflow", 0, frame_cycles);
            exp_entry.data      = sent[i];
            exp_entry.frame_err = 1'b0;
            check_entry("rx_overflow entry", exp_entry, rx_entry);
            pop_entry();
        end
        check_bit("rx_overflow ready", 1'b0, rx_ready);
        report_test("rx_overflow", e0);
    endtask

    task automatic test_logger();
        logic [7:0]  chars [6];
        logic [7:0]  got;
        logic        stop;
        logic [15:0] r;
        int          i;
        int          k;
        int          e0;
        e0 = errors;
        r = rand_bits(16);
        for (i = 0; i < 4; i++) chars[i] = hex_char(r[15 - 4 * i -: 4]);
        chars[4] = uart_pkg::ascii_cr;
        chars[5] = uart_pkg::ascii_lf;
        fork
            for (k = 0; k < 6; k++) begin
                decode_frame(1'b1, got, stop);
                check_byte("logger char", chars[k], got);
                check_bit("logger stop", 1'b1, stop);
            end
            begin
                log_trigger = 1'b1;
                log_value   = r;
                @(negedge clk);
                log_trigger = 1'b0;
                repeat (frame_cycles) @(negedge clk);
                check_bit("logger busy", 1'b1, log_busy);
                log_trigger = 1'b1;  // ignored while busy
                log_value   = ~r;
                @(negedge clk);
                log_trigger = 1'b0;
            end
        join
        wait_for("logger", 1, frame_cycles);
        expect_quiet("logger extra char", 1'b1, 2 * frame_cycles);
        report_test("logger", e0);
    endtask

    initial begin
        repeat (total_frames * frame_cycles * 3 + 5) @(posedge clk);
        $display("watchdog: tests did not finish in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        baud_div    = uart_pkg::baud_div_t'(div_val);
        tx_write    = 1'b0;
        tx_data     = '0;
        rx_pin      = 1'b1;
        rx_read     = 1'b0;
        log_trigger = 1'b0;
        log_value   = '0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_tx_order();
        test_tx_backpressure();
        test_rx();
        test_rx_overflow();
        test_logger();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
uart_pkg.sv
uart_rx.sv
uart_tx.sv
sync_fifo.sv
uart_core.sv
hex_logger.sv
serial_debug_top.sv
tb_serial_debug.sv
